// ==== logic/video_pkg.sv ====
// ##########################################################
// Video mode record and the predefined raster modes
// ##########################################################

package video_pkg;

    // Raster geometry for one direction is resolution, porches and sync width
    typedef struct packed {
        logic [15:0] h_resolution;
        logic [15:0] h_front_porch;
        logic [15:0] h_sync;
        logic [15:0] h_back_porch;
        logic        h_sync_pol;
        logic [15:0] v_resolution;
        logic [15:0] v_front_porch;
        logic [15:0] v_sync;
        logic [15:0] v_back_porch;
        logic        v_sync_pol;
    } video_mode_t;

    // Standard 640x480 at 60 Hz, both syncs active low
    localparam video_mode_t VMODE_640x480p60 = '{
        h_resolution:  16'd640,
        h_front_porch: 16'd16,
        h_sync:        16'd96,
        h_back_porch:  16'd48,
        h_sync_pol:    1'b0,
        v_resolution:  16'd480,
        v_front_porch: 16'd10,
        v_sync:        16'd2,
        v_back_porch:  16'd33,
        v_sync_pol:    1'b0
    };

    // Small mode for simulation
    // 41 clocks per line, 12 lines per frame
    localparam video_mode_t VMODE_TEST = '{
        h_resolution:  16'd32,
        h_front_porch: 16'd2,
        h_sync:        16'd3,
        h_back_porch:  16'd4,
        h_sync_pol:    1'b0,
        v_resolution:  16'd8,
        v_front_porch: 16'd1,
        v_sync:        16'd2,
        v_back_porch:  16'd1,
        v_sync_pol:    1'b1
    };

endpackage

// ==== logic/pixel_pkg.sv ====
// ##########################################################
// Pixel colour type and frame buffer configurations
// ##########################################################

package pixel_pkg;

    // 12-bit colour, 4 bits per component
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } color_t;

    // Buffer size in pixels and width of its address
    typedef struct packed {
        logic [15:0] width;
        logic [15:0] height;
        logic [7:0]  addr_width;
    } buffer_config_t;

    // Quarter resolution buffer for 640x480
    localparam buffer_config_t BUFFER_160x120x12 = '{
        width:      16'd160,
        height:     16'd120,
        addr_width: 8'd15
    };

    // Matches VMODE_TEST at a scale of 4
    localparam buffer_config_t BUFFER_TEST = '{
        width:      16'd8,
        height:     16'd2,
        addr_width: 8'd4
    };

endpackage

// ==== logic/raster_if.sv ====
// ##########################################################
// Raster position and timing levels
// ##########################################################
`timescale 1ns/100ps

interface raster_if #(
    parameter int XW = 10,
    parameter int YW = 10
);
    logic [XW-1:0] x;
    logic [YW-1:0] y;
    logic          hsync;
    logic          vsync;
    logic          data_enable;

    modport source (output x, y, hsync, vsync, data_enable);
    modport sink   (input  x, y, hsync, vsync, data_enable);
endinterface

// ==== logic/video_timing.sv ====
// ##########################################################
// Raster counters with sync and active area decoding
// ##########################################################
`timescale 1ns/100ps

module video_timing #(
    parameter video_pkg::video_mode_t VIDEO_MODE = video_pkg::VMODE_640x480p60
)(
    input logic      clk_pixel,
    input logic      rstn_pixel,
    raster_if.source raster
);
    localparam int H_RES     = VIDEO_MODE.h_resolution;
    localparam int H_SYNC_LO = H_RES + VIDEO_MODE.h_front_porch;
    localparam int H_SYNC_HI = H_SYNC_LO + VIDEO_MODE.h_sync;
    localparam int H_TOTAL   = H_SYNC_HI + VIDEO_MODE.h_back_porch;

    localparam int V_RES     = VIDEO_MODE.v_resolution;
    localparam int V_SYNC_LO = V_RES + VIDEO_MODE.v_front_porch;
    localparam int V_SYNC_HI = V_SYNC_LO + VIDEO_MODE.v_sync;
    localparam int V_TOTAL   = V_SYNC_HI + VIDEO_MODE.v_back_porch;

    localparam int XW = $clog2(H_TOTAL);
    localparam int YW = $clog2(V_TOTAL);

    logic [XW-1:0] x_count;
    logic [YW-1:0] y_count;
    logic          hsync_active;
    logic          vsync_active;

    // Line counter wraps every H_TOTAL clocks, frame counter steps on each wrap
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            x_count <= '0;
            y_count <= '0;
        end else if (x_count == XW'(H_TOTAL - 1)) begin
            x_count <= '0;
            if (y_count == YW'(V_TOTAL - 1)) begin
                y_count <= '0;
            end else begin
                y_count <= y_count + 1'b1;
            end
        end else begin
            x_count <= x_count + 1'b1;
        end
    end

    // Sync windows before polarity is applied
    always_comb begin
        hsync_active = (x_count >= XW'(H_SYNC_LO)) && (x_count < XW'(H_SYNC_HI));
        vsync_active = (y_count >= YW'(V_SYNC_LO)) && (y_count < YW'(V_SYNC_HI));
    end

    assign raster.x = x_count;
    assign raster.y = y_count;

    // Pin levels, inverted for active-low modes
    assign raster.hsync = VIDEO_MODE.h_sync_pol ? hsync_active : ~hsync_active;
    assign raster.vsync = VIDEO_MODE.v_sync_pol ? vsync_active : ~vsync_active;

    assign raster.data_enable = (x_count < XW'(H_RES)) && (y_count < YW'(V_RES));

endmodule

// ==== logic/frame_buffer.sv ====
// ##########################################################
// Dual-port pixel memory, one write and one read port
// ##########################################################
`timescale 1ns/100ps

module frame_buffer #(
    parameter pixel_pkg::buffer_config_t BUFFER_CONFIG = pixel_pkg::BUFFER_160x120x12
)(
    input  logic                                clk_pixel,

    input  logic                                write_en,
    input  logic [BUFFER_CONFIG.addr_width-1:0] write_addr,
    input  pixel_pkg::color_t                   write_data,

    input  logic [BUFFER_CONFIG.addr_width-1:0] read_addr,
    output pixel_pkg::color_t                   read_data
);
    localparam int DEPTH = BUFFER_CONFIG.width * BUFFER_CONFIG.height;

    pixel_pkg::color_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk_pixel) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // Registered read, a colliding write shows up one cycle later
    always_ff @(posedge clk_pixel) begin
        read_data <= mem[read_addr];
    end

endmodule

// ==== logic/display.sv ====
// ##########################################################
// Buffer address mapping, colour expansion and pin alignment
// ##########################################################
`timescale 1ns/100ps

module display #(
    parameter video_pkg::video_mode_t    VIDEO_MODE    = video_pkg::VMODE_640x480p60,
    parameter pixel_pkg::buffer_config_t BUFFER_CONFIG = pixel_pkg::BUFFER_160x120x12
)(
    input  logic                                clk_pixel,
    input  logic                                rstn_pixel,
    raster_if.sink                              raster,

    output logic [BUFFER_CONFIG.addr_width-1:0] read_addr,
    input  pixel_pkg::color_t                   read_data,

    output logic                                vga_hsync,
    output logic                                vga_vsync,
    output logic                                screen_data_enable,
    output logic [4:0]                          vga_red,
    output logic [5:0]                          vga_green,
    output logic [4:0]                          vga_blue
);
    localparam int ADDR_W = BUFFER_CONFIG.addr_width;
    localparam int BUF_W  = BUFFER_CONFIG.width;
    localparam int SCALE  = $clog2(VIDEO_MODE.h_resolution / BUFFER_CONFIG.width);

    // Inactive sync levels are the inverse of the polarity bit
    localparam logic HSYNC_IDLE = ~VIDEO_MODE.h_sync_pol;
    localparam logic VSYNC_IDLE = ~VIDEO_MODE.v_sync_pol;

    logic hsync_d1;
    logic vsync_d1;
    logic de_d1;

    // Each buffer pixel covers a 2^SCALE square of screen pixels
    assign read_addr = ADDR_W'(((32'(raster.y) >> SCALE) * BUF_W) + (32'(raster.x) >> SCALE));

    // First stage lines up with read_data
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            hsync_d1 <= HSYNC_IDLE;
            vsync_d1 <= VSYNC_IDLE;
            de_d1    <= 1'b0;
        end else begin
            hsync_d1 <= raster.hsync;
            vsync_d1 <= raster.vsync;
            de_d1    <= raster.data_enable;
        end
    end

    // Second stage drives the pins
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            vga_hsync          <= HSYNC_IDLE;
            vga_vsync          <= VSYNC_IDLE;
            screen_data_enable <= 1'b0;
            vga_red            <= '0;
            vga_green          <= '0;
            vga_blue           <= '0;
        end else begin
            vga_hsync          <= hsync_d1;
            vga_vsync          <= vsync_d1;
            screen_data_enable <= de_d1;
            if (de_d1) begin
                // 4-bit components into the top of the RGB565 fields
                vga_red   <= {read_data.red, 1'b0};
                vga_green <= {read_data.green, 2'b00};
                vga_blue  <= {read_data.blue, 1'b0};
            end else begin
                vga_red   <= '0;
                vga_green <= '0;
                vga_blue  <= '0;
            end
        end
    end

endmodule

// ==== logic/vga_top.sv ====
// ##########################################################
// VGA subsystem top, timing, frame buffer and display
// ##########################################################
`timescale 1ns/100ps

module vga_top #(
    parameter video_pkg::video_mode_t    VIDEO_MODE    = video_pkg::VMODE_640x480p60,
    parameter pixel_pkg::buffer_config_t BUFFER_CONFIG = pixel_pkg::BUFFER_160x120x12
)(
    input  logic                                clk_pixel,
    input  logic                                rstn_pixel,

    input  logic                                write_en,
    input  logic [BUFFER_CONFIG.addr_width-1:0] write_addr,
    input  pixel_pkg::color_t                   write_data,

    output logic                                vga_hsync,
    output logic                                vga_vsync,
    output logic                                screen_data_enable,
    output logic [4:0]                          vga_red,
    output logic [5:0]                          vga_green,
    output logic [4:0]                          vga_blue
);
    // Counter widths cover the full line and frame totals
    localparam int H_TOTAL = VIDEO_MODE.h_resolution + VIDEO_MODE.h_front_porch
                           + VIDEO_MODE.h_sync + VIDEO_MODE.h_back_porch;
    localparam int V_TOTAL = VIDEO_MODE.v_resolution + VIDEO_MODE.v_front_porch
                           + VIDEO_MODE.v_sync + VIDEO_MODE.v_back_porch;
    localparam int XW = $clog2(H_TOTAL);
    localparam int YW = $clog2(V_TOTAL);

    logic [BUFFER_CONFIG.addr_width-1:0] read_addr;
    pixel_pkg::color_t                   read_data;

    raster_if #(.XW(XW), .YW(YW)) raster ();

    video_timing #(
        .VIDEO_MODE (VIDEO_MODE)
    ) u_video_timing (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .raster     (raster.source)
    );

    frame_buffer #(
        .BUFFER_CONFIG (BUFFER_CONFIG)
    ) u_frame_buffer (
        .clk_pixel  (clk_pixel),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .read_addr  (read_addr),
        .read_data  (read_data)
    );

    display #(
        .VIDEO_MODE    (VIDEO_MODE),
        .BUFFER_CONFIG (BUFFER_CONFIG)
    ) u_display (
        .clk_pixel          (clk_pixel),
        .rstn_pixel         (rstn_pixel),
        .raster             (raster.sink),
        .read_addr          (read_addr),
        .read_data          (read_data),
        .vga_hsync          (vga_hsync),
        .vga_vsync          (vga_vsync),
        .screen_data_enable (screen_data_enable),
        .vga_red            (vga_red),
        .vga_green          (vga_green),
        .vga_blue           (vga_blue)
    );

endmodule

// ==== bench/vga_top_assert.sv ====
// ##########################################################
// Sync timing and blanking assertions, bound to vga_top
// ##########################################################
`timescale 1ns/100ps

module vga_top_assert #(
    parameter video_pkg::video_mode_t VIDEO_MODE = video_pkg::VMODE_TEST
)(
    input logic       clk_pixel,
    input logic       rstn_pixel,
    input logic       vga_hsync,
    input logic       screen_data_enable,
    input logic [4:0] vga_red,
    input logic [5:0] vga_green,
    input logic [4:0] vga_blue
);
    localparam int H_SYNC  = VIDEO_MODE.h_sync;
    localparam int H_TOTAL = VIDEO_MODE.h_resolution + VIDEO_MODE.h_front_porch
                           + VIDEO_MODE.h_sync + VIDEO_MODE.h_back_porch;

    int   fail_count = 0;
    logic h_active;

    assign h_active = (vga_hsync == VIDEO_MODE.h_sync_pol);

    // Pulse width in clocks
    assert property (@(posedge clk_pixel) disable iff (!rstn_pixel)
        $rose(h_active) |-> h_active[*H_SYNC] ##1 !h_active)
    else begin
        fail_count++;
        $error("hsync pulse is not %0d clocks long", H_SYNC);
    end

    // Next pulse starts one full line later
    assert property (@(posedge clk_pixel) disable iff (!rstn_pixel)
        $rose(h_active) |-> ##H_TOTAL $rose(h_active))
    else begin
        fail_count++;
        $error("hsync pulses are not %0d clocks apart", H_TOTAL);
    end

    assert property (@(posedge clk_pixel) disable iff (!rstn_pixel)
        !screen_data_enable |-> (vga_red == '0 && vga_green == '0 && vga_blue == '0))
    else begin
        fail_count++;
        $error("colour not blanked outside the active area");
    end

endmodule

bind vga_top vga_top_assert #(.VIDEO_MODE(VIDEO_MODE)) u_assert (.*);

// ==== bench/tb_vga_top.sv ====
// ##########################################################
// Testbench for vga_top with a shadow buffer and pixel monitor
// ##########################################################
`timescale 1ns/100ps

module tb_vga_top;
    localparam video_pkg::video_mode_t    MODE = video_pkg::VMODE_TEST;
    localparam pixel_pkg::buffer_config_t BUF  = pixel_pkg::BUFFER_TEST;
    localparam int H_RES   = MODE.h_resolution;
    localparam int V_RES   = MODE.v_resolution;
    localparam int H_TOTAL = H_RES + MODE.h_front_porch + MODE.h_sync + MODE.h_back_porch;
    localparam int DEPTH   = BUF.width * BUF.height;
    localparam int SCALE   = H_RES / BUF.width;

    logic                      clk_pixel = 1'b0;
    logic                      rstn_pixel, write_en;
    logic [BUF.addr_width-1:0] write_addr;
    pixel_pkg::color_t         write_data, expect_word;
    logic                      vga_hsync, vga_vsync, screen_data_enable;
    logic [4:0]                vga_red, vga_blue;
    logic [5:0]                vga_green;

    pixel_pkg::color_t shadow [DEPTH];
    logic [31:0]       lfsr_state = 32'h3b94_27dc;
    logic              timed_out = 1'b0;
    logic              de_prev = 1'b0;
    logic              vs_prev = 1'b0;
    int frame_count = 0, run_count = 0, de_len = 0, vs_len = 0;
    int pixels_checked = 0, pixel_errors = 0, timing_errors = 0;

    vga_top #(.VIDEO_MODE(MODE), .BUFFER_CONFIG(BUF)) dut (.*);

    initial begin
        forever #10 clk_pixel = ~clk_pixel;
    end

    // Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
    function automatic logic [11:0] next_color();
        logic [11:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < 12; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[10:0], fb};
        end
        return bits;
    endfunction

    // One word per clock, mirrored in the shadow copy
    task automatic write_buffer();
        for (int a = 0; a < DEPTH; a++) begin
            @(negedge clk_pixel);
            write_en   = 1'b1;
            write_addr = a[BUF.addr_width-1:0];
            write_data = next_color();
            shadow[a]  = write_data;
        end
        @(negedge clk_pixel);
        write_en = 1'b0;
    endtask

    // A frame is over once its last active run has left the pins
    task automatic wait_frame_done(input int frame);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_pixel);
            cycles++;
        end while (!(frame_count == frame && run_count == V_RES) && cycles < 2000);
        if (!(frame_count == frame && run_count == V_RES)) begin
            timed_out = 1'b1;
            $display("Timeout: frame %0d did not finish within 2000 clocks", frame);
        end
    endtask

    task automatic check_idle(input string phase);
        assert (vga_hsync == !MODE.h_sync_pol && vga_vsync == !MODE.v_sync_pol
                && !screen_data_enable && {vga_red, vga_green, vga_blue} == '0)
        else begin
            timing_errors++;
            $display("Fail at %0t: outputs not at rest %s", $time, phase);
        end
    endtask

    // Column is the index in a data-enable run, row counts runs since vsync
    always @(negedge clk_pixel) begin
        if (rstn_pixel) begin
            if (screen_data_enable && frame_count > 0) begin
                expect_word = shadow[(run_count / SCALE) * BUF.width + de_len / SCALE];
                pixels_checked++;
                assert (vga_red == 5'(expect_word.red) << 1
                        && vga_green == 6'(expect_word.green) << 2
                        && vga_blue == 5'(expect_word.blue) << 1)
                else begin
                    pixel_errors++;
                    $display("Fail at %0t: pixel (%0d,%0d) is %h/%h/%h, expected %h/%h/%h",
                             $time, de_len, run_count, vga_red, vga_green, vga_blue,
                             5'(expect_word.red) << 1, 6'(expect_word.green) << 2,
                             5'(expect_word.blue) << 1);
                end
            end
            if (screen_data_enable) begin
                de_len++;
            end else if (de_prev) begin
                assert (de_len == H_RES) else begin
                    timing_errors++;
                    $display("Fail at %0t: data enable run of %0d clocks", $time, de_len);
                end
                run_count++;
                de_len = 0;
            end
            if (vga_vsync == MODE.v_sync_pol) begin
                if (!vs_prev) begin
                    assert (run_count == V_RES) else begin
                        timing_errors++;
                        $display("Fail at %0t: frame had %0d active runs", $time, run_count);
                    end
                    frame_count++;
                    run_count = 0;
                end
                vs_len++;
            end else if (vs_prev) begin
                assert (vs_len == MODE.v_sync * H_TOTAL) else begin
                    timing_errors++;
                    $display("Fail at %0t: vsync active for %0d clocks", $time, vs_len);
                end
                vs_len = 0;
            end
            de_prev = screen_data_enable;
            vs_prev = (vga_vsync == MODE.v_sync_pol);
        end
    end

    initial begin
        rstn_pixel = 1'b0;
        write_en   = 1'b0;
        write_addr = '0;
        write_data = '0;
        repeat (3) begin
            @(negedge clk_pixel);
            check_idle("during reset");
        end
        rstn_pixel = 1'b1;
        @(negedge clk_pixel);
        check_idle("after reset");
        // Frame 0 loads the buffer, frame 1 is checked, then reload in vblank
        write_buffer();
        wait_frame_done(1);
        if (!timed_out) begin
            write_buffer();
            wait_frame_done(2);
            assert (pixels_checked == 2 * H_RES * V_RES) else begin
                timing_errors++;
                $display("Fail at %0t: only %0d pixels checked", $time, pixels_checked);
            end
        end
        $display("Pixels checked %0d, pixel errors %0d, timing errors %0d, assertion errors %0d",
                 pixels_checked, pixel_errors, timing_errors, dut.u_assert.fail_count);
        if (!timed_out && pixel_errors == 0 && timing_errors == 0
            && dut.u_assert.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
logic/video_pkg.sv
logic/pixel_pkg.sv
logic/raster_if.sv
logic/video_timing.sv
logic/frame_buffer.sv
logic/display.sv
logic/vga_top.sv
bench/vga_top_assert.sv
bench/tb_vga_top.sv

// ==== Bender.yml ====
package:
  name: vga_display

sources:
  - logic/video_pkg.sv
  - logic/pixel_pkg.sv
  - logic/raster_if.sv
  - logic/video_timing.sv
  - logic/frame_buffer.sv
  - logic/display.sv
  - logic/vga_top.sv
  - target: test
    files:
      - bench/vga_top_assert.sv
      - bench/tb_vga_top.sv
